// ==== include/pipe_ctrl_params.svh ====
`ifndef PIPE_CTRL_PARAMS_SVH
`define PIPE_CTRL_PARAMS_SVH

// instruction and register file geometry
`define INST_WIDTH 32
`define REG_ADDR_WIDTH 5

// exception cause field
`define ECODE_WIDTH 4

// cause values as in the privileged spec
`define ECODE_INST_ADDR_MISALIGNED `ECODE_WIDTH'd0
`define ECODE_ILLEGAL_INST `ECODE_WIDTH'd2
`define ECODE_BREAKPOINT `ECODE_WIDTH'd3
`define ECODE_LOAD_ADDR_MISALIGNED `ECODE_WIDTH'd4
`define ECODE_STORE_ADDR_MISALIGNED `ECODE_WIDTH'd6

// user-mode environment call only
`define ECODE_ECALL `ECODE_WIDTH'd8

`endif

// ==== source/pipe_ctrl_pkg.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

package pipe_ctrl_pkg;

	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

	// rv32 major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		OPC_LOAD = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC = 7'b0010111,
		OPC_STORE = 7'b0100011,
		OPC_OP = 7'b0110011,
		OPC_LUI = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR = 7'b1100111,
		OPC_JAL = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu encoding shared with the datapath
	typedef enum logic [3:0] {
		ALU_OP_ADD = 4'd0,
		ALU_OP_SUB = 4'd10,
		ALU_OP_SLL = 4'd1,
		ALU_OP_SLT = 4'd12,
		ALU_OP_SLTU = 4'd14,
		ALU_OP_XOR = 4'd4,
		ALU_OP_SRL = 4'd5,
		ALU_OP_SRA = 4'd11,
		ALU_OP_OR = 4'd6,
		ALU_OP_AND = 4'd7,
		ALU_OP_SEQ = 4'd8,
		ALU_OP_SNE = 4'd9,
		ALU_OP_SGE = 4'd13,
		ALU_OP_SGEU = 4'd15
	} alu_op_e;

	typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_type_e;
	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_sel_e;
	typedef enum logic [0:0] {WB_SRC_ALU, WB_SRC_MEM} wb_src_sel_e;

	typedef enum logic [2:0] {
		PC_PLUS_FOUR,
		PC_BRANCH_TARGET,
		PC_JAL_TARGET,
		PC_JALR_TARGET,
		PC_REPLAY,
		PC_HANDLER
	} pc_src_sel_e;

endpackage

`default_nettype wire

// ==== source/pipe_ctrl_if.sv ====
`default_nettype none

// decode results of the DX instruction, before any kill
interface dx_ctrl_if;
	import pipe_ctrl_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	logic uses_rs1;
	logic uses_rs2;
	logic wr_reg;
	wb_src_sel_e wb_src_sel;
	logic dmem_en;
	logic dmem_wen;
	logic branch_taken;
	logic jal;
	logic jalr;
	logic ebreak;
	logic ecall;
	logic illegal;

	modport decoder (
		output rs1_addr, rs2_addr, rd_addr, uses_rs1, uses_rs2, wr_reg, wb_src_sel,
		output dmem_en, dmem_wen, branch_taken, jal, jalr, ebreak, ecall, illegal
	);
	modport consumer (
		input rs1_addr, rs2_addr, rd_addr, uses_rs1, uses_rs2, wr_reg, wb_src_sel,
		input dmem_en, dmem_wen, branch_taken, jal, jalr, ebreak, ecall, illegal
	);
endinterface

// what the WB stage tells the earlier stages
interface wb_status_if;
	import pipe_ctrl_pkg::*;

	logic wr_reg;
	reg_addr_t reg_to_wr;
	logic load_in_wb;
	logic ex_wb;

	modport wb (output wr_reg, reg_to_wr, load_in_wb, ex_wb);
	modport observer (input wr_reg, reg_to_wr, load_in_wb, ex_wb);
endinterface

`default_nettype wire

// ==== source/inst_decoder.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

module inst_decoder (
	input wire logic [`INST_WIDTH-1:0] inst_dx,
	input wire logic cmp_true,
	dx_ctrl_if.decoder ctrl,
	output pipe_ctrl_pkg::imm_type_e imm_type,
	output pipe_ctrl_pkg::src_a_sel_e src_a_sel,
	output pipe_ctrl_pkg::src_b_sel_e src_b_sel,
	output pipe_ctrl_pkg::alu_op_e alu_op,
	output logic [2:0] dmem_size,
	output logic [2:0] dmem_type
);
	import pipe_ctrl_pkg::*;

	opcode_e opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic [11:0] funct12;
	alu_op_e alu_op_arith;

	assign opcode = opcode_e'(inst_dx[6:0]);
	assign funct7 = inst_dx[31:25];
	assign funct3 = inst_dx[14:12];
	assign funct12 = inst_dx[31:20];

	assign ctrl.rs1_addr = inst_dx[19:15];
	assign ctrl.rs2_addr = inst_dx[24:20];
	assign ctrl.rd_addr = inst_dx[11:7];

	// width and sign extension come straight from funct3
	assign dmem_size = {1'b0, funct3[1:0]};
	assign dmem_type = funct3;

	// register-register and register-immediate arithmetic
	always_comb begin
		case (funct3)
			3'b000: alu_op_arith = (opcode == OPC_OP && funct7[5]) ? ALU_OP_SUB : ALU_OP_ADD;
			3'b001: alu_op_arith = ALU_OP_SLL;
			3'b010: alu_op_arith = ALU_OP_SLT;
			3'b011: alu_op_arith = ALU_OP_SLTU;
			3'b100: alu_op_arith = ALU_OP_XOR;
			3'b101: alu_op_arith = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
			3'b110: alu_op_arith = ALU_OP_OR;
			default: alu_op_arith = ALU_OP_AND;
		endcase
	end

	// defaults first, then per-opcode overrides
	always_comb begin
		ctrl.uses_rs1 = 1'b1;
		ctrl.uses_rs2 = 1'b0;
		ctrl.wr_reg = 1'b0;
		ctrl.wb_src_sel = WB_SRC_ALU;
		ctrl.dmem_en = 1'b0;
		ctrl.dmem_wen = 1'b0;
		ctrl.branch_taken = 1'b0;
		ctrl.jal = 1'b0;
		ctrl.jalr = 1'b0;
		ctrl.ebreak = 1'b0;
		ctrl.ecall = 1'b0;
		ctrl.illegal = 1'b0;
		imm_type = IMM_I;
		src_a_sel = SRC_A_RS1;
		src_b_sel = SRC_B_IMM;
		alu_op = ALU_OP_ADD;
		case (opcode)
			OPC_LOAD: begin
				ctrl.dmem_en = 1'b1;
				ctrl.wr_reg = 1'b1;
				ctrl.wb_src_sel = WB_SRC_MEM;
				// no 64-bit or unsigned-word loads
				ctrl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			OPC_STORE: begin
				ctrl.uses_rs2 = 1'b1;
				ctrl.dmem_en = 1'b1;
				ctrl.dmem_wen = 1'b1;
				imm_type = IMM_S;
				ctrl.illegal = (funct3 > 3'b010);
			end
			OPC_BRANCH: begin
				ctrl.uses_rs2 = 1'b1;
				ctrl.branch_taken = cmp_true;
				src_b_sel = SRC_B_RS2;
				case (funct3)
					3'b000: alu_op = ALU_OP_SEQ;
					3'b001: alu_op = ALU_OP_SNE;
					3'b100: alu_op = ALU_OP_SLT;
					3'b101: alu_op = ALU_OP_SGE;
					3'b110: alu_op = ALU_OP_SLTU;
					3'b111: alu_op = ALU_OP_SGEU;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				ctrl.jal = 1'b1;
				ctrl.uses_rs1 = 1'b0;
				ctrl.wr_reg = 1'b1;
				src_a_sel = SRC_A_PC;
				src_b_sel = SRC_B_FOUR;
			end
			OPC_JALR: begin
				// link value is pc + 4, target comes from the datapath adder
				ctrl.jalr = 1'b1;
				ctrl.wr_reg = 1'b1;
				src_a_sel = SRC_A_PC;
				src_b_sel = SRC_B_FOUR;
				ctrl.illegal = (funct3 != 3'b000);
			end
			OPC_MISC_MEM: begin
				// fence is a no-op on this in-order core
				if (funct3 != 3'b000 || inst_dx[31:28] != 4'b0000 ||
						ctrl.rs1_addr != '0 || ctrl.rd_addr != '0) begin
					ctrl.illegal = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				alu_op = alu_op_arith;
				ctrl.wr_reg = 1'b1;
				// upper bits of a shift immediate are reserved
				if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
					ctrl.illegal = 1'b1;
				end
				if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000) begin
					ctrl.illegal = 1'b1;
				end
			end
			OPC_OP: begin
				ctrl.uses_rs2 = 1'b1;
				ctrl.wr_reg = 1'b1;
				src_b_sel = SRC_B_RS2;
				alu_op = alu_op_arith;
			end
			OPC_AUIPC: begin
				ctrl.uses_rs1 = 1'b0;
				ctrl.wr_reg = 1'b1;
				src_a_sel = SRC_A_PC;
				imm_type = IMM_U;
			end
			OPC_LUI: begin
				ctrl.uses_rs1 = 1'b0;
				ctrl.wr_reg = 1'b1;
				src_a_sel = SRC_A_ZERO;
				imm_type = IMM_U;
			end
			OPC_SYSTEM: begin
				// only ecall and ebreak, no csr access
				if (funct3 == 3'b000 && ctrl.rs1_addr == '0 && ctrl.rd_addr == '0) begin
					case (funct12)
						12'h000: ctrl.ecall = 1'b1;
						12'h001: ctrl.ebreak = 1'b1;
						default: ctrl.illegal = 1'b1;
					endcase
				end else begin
					ctrl.illegal = 1'b1;
				end
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/fetch_dx_ctrl.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

module fetch_dx_ctrl (
	input wire logic clk,
	input wire logic reset,
	input wire logic imem_wait,
	input wire logic imem_badmem_e,
	dx_ctrl_if.consumer ctrl,
	wb_status_if.observer wb,
	input wire logic stall_wb,
	input wire logic load_use,
	output logic stall_if,
	output logic kill_if,
	output logic stall_dx,
	output logic kill_dx,
	output logic ex_dx,
	output logic killed_dx,
	output logic [`ECODE_WIDTH-1:0] ex_code_dx,
	output logic dmem_en,
	output logic dmem_wen,
	output pipe_ctrl_pkg::pc_src_sel_e pc_src_sel
);
	import pipe_ctrl_pkg::*;

	logic replay_if;
	logic had_ex_dx;
	logic prev_killed_dx;
	logic ex_if;
	logic new_ex_dx;
	logic branch_taken;
	logic jal;
	logic jalr;
	logic redirect;

	// a redirect that meets an imem wait must be fetched again
	always_ff @(posedge clk) begin
		if (reset) begin
			replay_if <= 1'b1;
		end else begin
			replay_if <= redirect && imem_wait;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			had_ex_dx <= 1'b0;
			prev_killed_dx <= 1'b1;
		end else if (!stall_dx) begin
			had_ex_dx <= ex_if;
			prev_killed_dx <= kill_if;
		end
	end

	assign ex_if = imem_badmem_e && !imem_wait && !redirect && !replay_if;
	assign stall_if = stall_dx || (imem_wait && !redirect && !wb.ex_wb);
	assign kill_if = stall_if || ex_if || ex_dx || wb.ex_wb || redirect || replay_if;

	// exceptions never wait behind a load-use stall
	assign stall_dx = stall_wb || (load_use && !(ex_dx || wb.ex_wb));
	assign kill_dx = stall_dx || ex_dx || wb.ex_wb;
	assign killed_dx = prev_killed_dx || kill_dx;

	// a bubble in DX carries no new cause
	assign new_ex_dx = (ctrl.illegal || ctrl.ebreak || ctrl.ecall) && !prev_killed_dx;
	assign ex_dx = had_ex_dx || new_ex_dx;

	always_comb begin
		if (had_ex_dx) begin
			ex_code_dx = `ECODE_INST_ADDR_MISALIGNED;
		end else if (ctrl.illegal) begin
			ex_code_dx = `ECODE_ILLEGAL_INST;
		end else if (ctrl.ebreak) begin
			ex_code_dx = `ECODE_BREAKPOINT;
		end else if (ctrl.ecall) begin
			ex_code_dx = `ECODE_ECALL;
		end else begin
			ex_code_dx = `ECODE_INST_ADDR_MISALIGNED;
		end
	end

	assign branch_taken = ctrl.branch_taken && !killed_dx;
	assign jal = ctrl.jal && !killed_dx;
	assign jalr = ctrl.jalr && !killed_dx;
	assign redirect = branch_taken || jal || jalr;

	assign dmem_en = ctrl.dmem_en && !killed_dx;
	assign dmem_wen = ctrl.dmem_wen && !killed_dx;

	always_comb begin
		if (wb.ex_wb) begin
			pc_src_sel = PC_HANDLER;
		end else if (replay_if || (stall_if && !imem_wait)) begin
			pc_src_sel = PC_REPLAY;
		end else if (branch_taken) begin
			pc_src_sel = PC_BRANCH_TARGET;
		end else if (jal) begin
			pc_src_sel = PC_JAL_TARGET;
		end else if (jalr) begin
			pc_src_sel = PC_JALR_TARGET;
		end else begin
			pc_src_sel = PC_PLUS_FOUR;
		end
	end

endmodule

`default_nettype wire

// ==== source/wb_ctrl.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

module wb_ctrl (
	input wire logic clk,
	input wire logic reset,
	input wire logic dmem_wait,
	input wire logic dmem_badmem_e,
	dx_ctrl_if.consumer ctrl,
	input wire logic kill_dx,
	input wire logic stall_dx,
	input wire logic ex_dx,
	input wire logic killed_dx,
	input wire logic [`ECODE_WIDTH-1:0] ex_code_dx,
	wb_status_if.wb status,
	output logic stall_wb,
	output logic kill_wb,
	output logic wr_reg_wb,
	output logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb,
	output pipe_ctrl_pkg::wb_src_sel_e wb_src_sel_wb,
	output logic exception_wb,
	output logic [`ECODE_WIDTH-1:0] exception_code_wb,
	output logic retire_wb
);

	logic prev_killed_wb;
	logic had_ex_wb;
	logic wr_reg_unkilled_wb;
	logic dmem_en_wb;
	logic store_in_wb;
	logic [`ECODE_WIDTH-1:0] prev_ex_code_wb;
	logic mem_in_wb;
	logic dmem_fault;
	logic ex_wb;

	always_ff @(posedge clk) begin
		if (reset) begin
			prev_killed_wb <= 1'b1;
			had_ex_wb <= 1'b0;
			wr_reg_unkilled_wb <= 1'b0;
			dmem_en_wb <= 1'b0;
			store_in_wb <= 1'b0;
		end else if (!stall_wb) begin
			prev_killed_wb <= killed_dx;
			had_ex_wb <= ex_dx;
			wr_reg_unkilled_wb <= ctrl.wr_reg && !kill_dx;
			dmem_en_wb <= ctrl.dmem_en && !kill_dx;
			store_in_wb <= ctrl.dmem_wen && !kill_dx;
		end
	end

	// a held DX stage only sends a bubble, so payload keeps its value
	always_ff @(posedge clk) begin
		if (!stall_wb && !stall_dx) begin
			reg_to_wr_wb <= ctrl.rd_addr;
			wb_src_sel_wb <= ctrl.wb_src_sel;
			prev_ex_code_wb <= ex_code_dx;
		end
	end

	assign mem_in_wb = dmem_en_wb && !prev_killed_wb;
	assign dmem_fault = dmem_badmem_e && mem_in_wb;
	assign ex_wb = had_ex_wb || dmem_fault;

	assign stall_wb = dmem_wait && mem_in_wb && !ex_wb;
	assign kill_wb = stall_wb || ex_wb;

	// loads write a register, stores do not
	always_comb begin
		if (had_ex_wb) begin
			exception_code_wb = prev_ex_code_wb;
		end else if (wr_reg_unkilled_wb) begin
			exception_code_wb = `ECODE_LOAD_ADDR_MISALIGNED;
		end else begin
			exception_code_wb = `ECODE_STORE_ADDR_MISALIGNED;
		end
	end

	assign exception_wb = ex_wb;
	assign wr_reg_wb = wr_reg_unkilled_wb && !prev_killed_wb && !kill_wb;
	assign retire_wb = !(kill_wb || prev_killed_wb);

	assign status.wr_reg = wr_reg_wb;
	assign status.reg_to_wr = reg_to_wr_wb;
	assign status.load_in_wb = mem_in_wb && !store_in_wb;
	assign status.ex_wb = ex_wb;

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
	dx_ctrl_if.consumer ctrl,
	wb_status_if.observer wb,
	output logic bypass_rs1,
	output logic bypass_rs2,
	output logic load_use
);

	logic raw_rs1;
	logic raw_rs2;

	// x0 is never a real dependency
	assign raw_rs1 = wb.wr_reg && ctrl.uses_rs1 && (ctrl.rs1_addr == wb.reg_to_wr) &&
		(ctrl.rs1_addr != '0);
	assign raw_rs2 = wb.wr_reg && ctrl.uses_rs2 && (ctrl.rs2_addr == wb.reg_to_wr) &&
		(ctrl.rs2_addr != '0);

	// load data arrives too late to forward
	assign bypass_rs1 = raw_rs1 && !wb.load_in_wb;
	assign bypass_rs2 = raw_rs2 && !wb.load_in_wb;
	assign load_use = wb.load_in_wb && (raw_rs1 || raw_rs2);

endmodule

`default_nettype wire

// ==== source/pipe_ctrl_top.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

module pipe_ctrl_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`INST_WIDTH-1:0] inst_dx,
	input wire logic imem_wait,
	input wire logic imem_badmem_e,
	input wire logic dmem_wait,
	input wire logic dmem_badmem_e,
	input wire logic cmp_true,
	output pipe_ctrl_pkg::pc_src_sel_e pc_src_sel,
	output pipe_ctrl_pkg::imm_type_e imm_type,
	output pipe_ctrl_pkg::src_a_sel_e src_a_sel,
	output pipe_ctrl_pkg::src_b_sel_e src_b_sel,
	output pipe_ctrl_pkg::alu_op_e alu_op,
	output logic bypass_rs1,
	output logic bypass_rs2,
	output logic dmem_en,
	output logic dmem_wen,
	output logic [2:0] dmem_size,
	output logic [2:0] dmem_type,
	output logic wr_reg_wb,
	output logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb,
	output pipe_ctrl_pkg::wb_src_sel_e wb_src_sel_wb,
	output logic stall_if,
	output logic kill_if,
	output logic stall_dx,
	output logic kill_dx,
	output logic stall_wb,
	output logic kill_wb,
	output logic exception_wb,
	output logic [`ECODE_WIDTH-1:0] exception_code_wb,
	output logic retire_wb
);

	logic ex_dx;
	logic killed_dx;
	logic [`ECODE_WIDTH-1:0] ex_code_dx;
	logic load_use;

	dx_ctrl_if dx_ctrl ();
	wb_status_if wb_status ();

	inst_decoder inst_decoder_i (
		.inst_dx(inst_dx),
		.cmp_true(cmp_true),
		.ctrl(dx_ctrl.decoder),
		.imm_type(imm_type),
		.src_a_sel(src_a_sel),
		.src_b_sel(src_b_sel),
		.alu_op(alu_op),
		.dmem_size(dmem_size),
		.dmem_type(dmem_type)
	);

	fetch_dx_ctrl fetch_dx_ctrl_i (
		.clk(clk),
		.reset(reset),
		.imem_wait(imem_wait),
		.imem_badmem_e(imem_badmem_e),
		.ctrl(dx_ctrl.consumer),
		.wb(wb_status.observer),
		.stall_wb(stall_wb),
		.load_use(load_use),
		.stall_if(stall_if),
		.kill_if(kill_if),
		.stall_dx(stall_dx),
		.kill_dx(kill_dx),
		.ex_dx(ex_dx),
		.killed_dx(killed_dx),
		.ex_code_dx(ex_code_dx),
		.dmem_en(dmem_en),
		.dmem_wen(dmem_wen),
		.pc_src_sel(pc_src_sel)
	);

	wb_ctrl wb_ctrl_i (
		.clk(clk),
		.reset(reset),
		.dmem_wait(dmem_wait),
		.dmem_badmem_e(dmem_badmem_e),
		.ctrl(dx_ctrl.consumer),
		.kill_dx(kill_dx),
		.stall_dx(stall_dx),
		.ex_dx(ex_dx),
		.killed_dx(killed_dx),
		.ex_code_dx(ex_code_dx),
		.status(wb_status.wb),
		.stall_wb(stall_wb),
		.kill_wb(kill_wb),
		.wr_reg_wb(wr_reg_wb),
		.reg_to_wr_wb(reg_to_wr_wb),
		.wb_src_sel_wb(wb_src_sel_wb),
		.exception_wb(exception_wb),
		.exception_code_wb(exception_code_wb),
		.retire_wb(retire_wb)
	);

	hazard_unit hazard_unit_i (
		.ctrl(dx_ctrl.consumer),
		.wb(wb_status.observer),
		.bypass_rs1(bypass_rs1),
		.bypass_rs2(bypass_rs2),
		.load_use(load_use)
	);

endmodule

`default_nettype wire

// ==== tb/pipe_ctrl_properties.sv ====
`default_nettype none

module pipe_ctrl_properties (
	input wire logic clk,
	input wire logic reset,
	input wire logic kill_dx,
	input wire logic dmem_en,
	input wire logic dmem_wen,
	input wire logic stall_if,
	input wire logic kill_if,
	input wire logic exception_wb,
	input wire logic wr_reg_wb,
	input wire logic bypass_rs1,
	input wire logic bypass_rs2,
	input wire logic load_use
);

	// a killed DX stage never touches data memory
	assert property (@(posedge clk) disable iff (reset) kill_dx |-> !dmem_en && !dmem_wen)
		else $error("memory enable active while DX is killed");

	assert property (@(posedge clk) disable iff (reset) stall_if |-> kill_if)
		else $error("IF stalled without being killed");

	// a faulting instruction must not write the register file
	assert property (@(posedge clk) disable iff (reset) exception_wb |-> !wr_reg_wb)
		else $error("register write during a WB exception");

	assert property (@(posedge clk) disable iff (reset)
		!((bypass_rs1 || bypass_rs2) && load_use))
		else $error("bypass and load-use raised together");

endmodule

bind pipe_ctrl_top pipe_ctrl_properties pipe_ctrl_properties_i (
	.clk(clk),
	.reset(reset),
	.kill_dx(kill_dx),
	.dmem_en(dmem_en),
	.dmem_wen(dmem_wen),
	.stall_if(stall_if),
	.kill_if(kill_if),
	.exception_wb(exception_wb),
	.wr_reg_wb(wr_reg_wb),
	.bypass_rs1(bypass_rs1),
	.bypass_rs2(bypass_rs2),
	.load_use(load_use)
);

`default_nettype wire

// ==== tb/pipe_ctrl_tb.sv ====
`default_nettype none

`include "pipe_ctrl_params.svh"

module pipe_ctrl_tb;
	import pipe_ctrl_pkg::*;

	localparam logic [31:0] NOP = 32'h0000_0013;

	// mode 0 plain, 1 fetch fault, 2 dmem wait, 3 dmem fault
	typedef struct packed {
		logic use_lead;
		logic [31:0] lead;
		logic [31:0] inst;
		logic cmp;
		logic [1:0] mode;
		alu_op_e alu;
		imm_type_e imm;
		src_a_sel_e sa;
		src_b_sel_e sb;
		logic den;
		logic dwen;
		pc_src_sel_e pc;
		logic byp1;
		logic byp2;
		logic stall;
		logic wr;
		wb_src_sel_e wbsrc;
		logic exc;
		logic [3:0] ecode;
	} row_t;

	logic clk;
	logic reset;
	logic [`INST_WIDTH-1:0] inst_dx;
	logic imem_wait;
	logic imem_badmem_e;
	logic dmem_wait;
	logic dmem_badmem_e;
	logic cmp_true;
	pc_src_sel_e pc_src_sel;
	imm_type_e imm_type;
	src_a_sel_e src_a_sel;
	src_b_sel_e src_b_sel;
	alu_op_e alu_op;
	logic bypass_rs1;
	logic bypass_rs2;
	logic dmem_en;
	logic dmem_wen;
	logic [2:0] dmem_size;
	logic [2:0] dmem_type;
	logic wr_reg_wb;
	logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb;
	wb_src_sel_e wb_src_sel_wb;
	logic stall_if;
	logic kill_if;
	logic stall_dx;
	logic kill_dx;
	logic stall_wb;
	logic kill_wb;
	logic exception_wb;
	logic [`ECODE_WIDTH-1:0] exception_code_wb;
	logic retire_wb;

	row_t rows[$];
	integer seed = 32'h7828_8ed4;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 1000;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] r;

	pipe_ctrl_top pipe_ctrl_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("ERROR: run did not complete within %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] b, logic [4:0] a,
			logic [2:0] f3, logic [4:0] d, logic [6:0] op);
		return {f7, b, a, f3, d, op};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] a, logic [2:0] f3,
			logic [4:0] d, logic [6:0] op);
		return {imm, a, f3, d, op};
	endfunction

	// log2 of the access width in bytes for a load or store funct3
	function automatic logic [2:0] access_size(input logic [2:0] f3);
		case (f3)
			3'd0, 3'd4: return 3'd0;
			3'd1, 3'd5: return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic new_regs();
		rd = 5'($random(seed));
		rs1 = 5'($random(seed));
		rs2 = 5'($random(seed));
		r = 5'($random(seed)) | 5'd1;
	endtask

	task automatic add_row(input logic [31:0] inst, input logic cmp, input alu_op_e alu,
			input imm_type_e imm, input src_a_sel_e sa, input src_b_sel_e sb,
			input logic den, input logic dwen, input pc_src_sel_e pc, input logic wr,
			input wb_src_sel_e wbsrc, input logic exc, input logic [3:0] ecode);
		row_t row;
		row = '{use_lead: 1'b0, lead: NOP, inst: inst, cmp: cmp, mode: 2'd0, alu: alu,
			imm: imm, sa: sa, sb: sb, den: den, dwen: dwen, pc: pc, byp1: 1'b0,
			byp2: 1'b0, stall: 1'b0, wr: wr, wbsrc: wbsrc, exc: exc, ecode: ecode};
		rows.push_back(row);
	endtask

	// adds a leading instruction, mode and hazard results to the newest row
	task automatic amend_last(input logic use_lead, input logic [31:0] lead,
			input logic [1:0] mode, input logic byp1, input logic byp2, input logic stall);
		row_t row;
		row = rows.pop_back();
		row.use_lead = use_lead;
		row.lead = lead;
		row.mode = mode;
		row.byp1 = byp1;
		row.byp2 = byp2;
		row.stall = stall;
		rows.push_back(row);
	endtask

	task automatic drive_idle();
		inst_dx = NOP;
		cmp_true = 1'b0;
		imem_wait = 1'b0;
		imem_badmem_e = 1'b0;
		dmem_wait = 1'b0;
		dmem_badmem_e = 1'b0;
	endtask

	// idle until IF is no longer killed, so DX holds a live instruction
	task automatic wait_live();
		@(negedge clk);
		drive_idle();
		#1;
		while (kill_if) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
	endtask

	task automatic run_row(input row_t row);
		wait_live();
		if (row.use_lead) begin
			inst_dx = row.lead;
			@(negedge clk);
		end
		inst_dx = row.inst;
		cmp_true = row.cmp;
		imem_badmem_e = (row.mode == 2'd1);
		#1;
		check("alu_op", 32'(alu_op), 32'(row.alu));
		check("imm_type", 32'(imm_type), 32'(row.imm));
		check("src_a_sel", 32'(src_a_sel), 32'(row.sa));
		check("src_b_sel", 32'(src_b_sel), 32'(row.sb));
		check("dmem_en", 32'(dmem_en), 32'(row.den));
		check("dmem_wen", 32'(dmem_wen), 32'(row.dwen));
		check("pc_src_sel", 32'(pc_src_sel), 32'(row.pc));
		check("bypass_rs1", 32'(bypass_rs1), 32'(row.byp1));
		check("bypass_rs2", 32'(bypass_rs2), 32'(row.byp2));
		check("stall_dx", 32'(stall_dx), 32'(row.stall));
		// causes found in DX and a load-use stall both kill DX
		check("kill_dx", 32'(kill_dx), 32'(row.stall || (row.exc && row.mode == 2'd0)));
		if (row.den) begin
			check("dmem_size", 32'(dmem_size), 32'(access_size(row.inst[14:12])));
			// type is the load/store funct3 itself
			check("dmem_type", 32'(dmem_type), 32'(row.inst[14:12]));
		end
		while (stall_dx) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		drive_idle();
		if (row.mode == 2'd1) begin
			@(negedge clk);
		end
		if (row.mode == 2'd2) begin
			repeat (3) begin
				dmem_wait = 1'b1;
				#1;
				check("stall_wb", 32'(stall_wb), 32'd1);
				check("kill_wb held", 32'(kill_wb), 32'd1);
				check("stall_dx held", 32'(stall_dx), 32'd1);
				check("stall_if", 32'(stall_if), 32'd1);
				@(negedge clk);
			end
			dmem_wait = 1'b0;
		end
		dmem_badmem_e = (row.mode == 2'd3);
		#1;
		check("wr_reg_wb", 32'(wr_reg_wb), 32'(row.wr));
		if (row.wr) begin
			check("reg_to_wr_wb", 32'(reg_to_wr_wb), 32'(row.inst[11:7]));
			check("wb_src_sel_wb", 32'(wb_src_sel_wb), 32'(row.wbsrc));
		end
		check("exception_wb", 32'(exception_wb), 32'(row.exc));
		if (row.exc) begin
			check("exception_code_wb", 32'(exception_code_wb), 32'(row.ecode));
		end
		check("kill_wb", 32'(kill_wb), 32'(row.exc));
		check("retire_wb", 32'(retire_wb), 32'(!row.exc));
		check("pc_src_sel in WB", 32'(pc_src_sel), 32'(row.exc ? PC_HANDLER : PC_PLUS_FOUR));
	endtask

	task automatic build_rows();
		new_regs();
		add_row(enc_r(7'h00, rs2, rs1, 3'd0, rd, OPC_OP), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_r(7'h20, rs2, rs1, 3'd0, rd, OPC_OP), 0, ALU_OP_SUB, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_r(7'h20, rs2, rs1, 3'd5, rd, OPC_OP), 0, ALU_OP_SRA, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_r(7'h00, rs2, rs1, 3'd3, rd, OPC_OP), 0, ALU_OP_SLTU, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_i(12'h5a5, rs1, 3'd4, rd, OPC_OP_IMM), 0, ALU_OP_XOR, IMM_I, SRC_A_RS1,
			SRC_B_IMM, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_r(7'h00, rs2, rs1, 3'd5, rd, OPC_OP_IMM), 0, ALU_OP_SRL, IMM_I,
			SRC_A_RS1, SRC_B_IMM, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row(enc_r(7'h20, rs2, rs1, 3'd5, rd, OPC_OP_IMM), 0, ALU_OP_SRA, IMM_I,
			SRC_A_RS1, SRC_B_IMM, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		new_regs();
		add_row({20'h12345, rd, 7'(OPC_LUI)}, 0, ALU_OP_ADD, IMM_U, SRC_A_ZERO, SRC_B_IMM,
			0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		add_row({20'h0abcd, rd, 7'(OPC_AUIPC)}, 0, ALU_OP_ADD, IMM_U, SRC_A_PC, SRC_B_IMM,
			0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		add_row(enc_i(12'h010, rs1, 3'd2, rd, OPC_LOAD), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_IMM, 1, 1'b0, PC_PLUS_FOUR, 1, WB_SRC_MEM, 0, 4'd0);
		add_row(enc_r(7'h00, rs2, rs1, 3'd2, 5'd8, OPC_STORE), 0, ALU_OP_ADD, IMM_S,
			SRC_A_RS1, SRC_B_IMM, 1, 1, PC_PLUS_FOUR, 0, WB_SRC_ALU, 0, 4'd0);
		add_row(enc_r(7'h00, rs2, rs1, 3'd0, 5'd4, OPC_BRANCH), 1, ALU_OP_SEQ, IMM_I,
			SRC_A_RS1, SRC_B_RS2, 0, 0, PC_BRANCH_TARGET, 0, WB_SRC_ALU, 0, 4'd0);
		add_row(enc_r(7'h00, rs2, rs1, 3'd7, 5'd4, OPC_BRANCH), 0, ALU_OP_SGEU, IMM_I,
			SRC_A_RS1, SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 0, WB_SRC_ALU, 0, 4'd0);
		add_row({20'h00100, rd, 7'(OPC_JAL)}, 0, ALU_OP_ADD, IMM_I, SRC_A_PC, SRC_B_FOUR,
			0, 0, PC_JAL_TARGET, 1, WB_SRC_ALU, 0, 4'd0);
		add_row(enc_i(12'h000, rs1, 3'd0, rd, OPC_JALR), 0, ALU_OP_ADD, IMM_I, SRC_A_PC,
			SRC_B_FOUR, 0, 0, PC_JALR_TARGET, 1, WB_SRC_ALU, 0, 4'd0);
		add_row(32'h0ff0_000f, 0, ALU_OP_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM, 0, 0,
			PC_PLUS_FOUR, 0, WB_SRC_ALU, 0, 4'd0);
		add_row(32'h0000_0073, 0, ALU_OP_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM, 0, 0,
			PC_PLUS_FOUR, 0, WB_SRC_ALU, 1, `ECODE_ECALL);
		add_row(32'h0010_0073, 0, ALU_OP_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM, 0, 0,
			PC_PLUS_FOUR, 0, WB_SRC_ALU, 1, `ECODE_BREAKPOINT);
		add_row(32'h0000_0000, 0, ALU_OP_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM, 0, 0,
			PC_PLUS_FOUR, 0, WB_SRC_ALU, 1, `ECODE_ILLEGAL_INST);
		// doubleword load does not exist in rv32
		add_row(enc_i(12'h000, rs1, 3'd3, rd, OPC_LOAD), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_IMM, 0, 0, PC_PLUS_FOUR, 0, WB_SRC_ALU, 1, `ECODE_ILLEGAL_INST);
		// hazards against the instruction ahead in WB
		new_regs();
		add_row(enc_r(7'h00, 5'd0, r, 3'd0, rd, OPC_OP), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		amend_last(1, enc_i(12'd1, 5'd0, 3'd0, r, OPC_OP_IMM), 2'd0, 1, 0, 0);
		new_regs();
		add_row(enc_r(7'h00, r, 5'd0, 3'd0, rd, OPC_OP), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		amend_last(1, enc_i(12'd1, 5'd0, 3'd0, r, OPC_OP_IMM), 2'd0, 0, 1, 0);
		add_row(enc_r(7'h00, 5'd0, 5'd0, 3'd0, rd, OPC_OP), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_PLUS_FOUR, 1, WB_SRC_ALU, 0, 4'd0);
		amend_last(1, enc_i(12'd1, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), 2'd0, 0, 0, 0);
		new_regs();
		add_row(enc_r(7'h00, 5'd0, r, 3'd0, rd, OPC_OP), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_RS2, 0, 0, PC_REPLAY, 1, WB_SRC_ALU, 0, 4'd0);
		amend_last(1, enc_i(12'd0, rs1, 3'd2, r, OPC_LOAD), 2'd0, 0, 0, 1);
		// data memory back-pressure and faults
		new_regs();
		add_row(enc_i(12'h020, rs1, 3'd2, rd, OPC_LOAD), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_IMM, 1, 0, PC_PLUS_FOUR, 1, WB_SRC_MEM, 0, 4'd0);
		amend_last(0, NOP, 2'd2, 0, 0, 0);
		add_row(enc_i(12'h021, rs1, 3'd2, rd, OPC_LOAD), 0, ALU_OP_ADD, IMM_I, SRC_A_RS1,
			SRC_B_IMM, 1, 0, PC_PLUS_FOUR, 0, WB_SRC_MEM, 1, `ECODE_LOAD_ADDR_MISALIGNED);
		amend_last(0, NOP, 2'd3, 0, 0, 0);
		add_row(enc_r(7'h00, rs2, rs1, 3'd2, 5'd3, OPC_STORE), 0, ALU_OP_ADD, IMM_S,
			SRC_A_RS1, SRC_B_IMM, 1, 1, PC_PLUS_FOUR, 0, WB_SRC_ALU, 1,
			`ECODE_STORE_ADDR_MISALIGNED);
		amend_last(0, NOP, 2'd3, 0, 0, 0);
		add_row(NOP, 0, ALU_OP_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM, 0, 0, PC_PLUS_FOUR, 0,
			WB_SRC_ALU, 1, `ECODE_INST_ADDR_MISALIGNED);
		amend_last(0, NOP, 2'd1, 0, 0, 0);
	endtask

	initial begin
		reset = 1'b1;
		drive_idle();
		build_rows();
		limit = 16 + 8 * rows.size();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check("kill_if after reset", 32'(kill_if), 32'd1);
		check("pc_src_sel after reset", 32'(pc_src_sel), 32'(PC_REPLAY));
		check("retire_wb after reset", 32'(retire_wb), 32'd0);
		check("wr_reg_wb after reset", 32'(wr_reg_wb), 32'd0);
		check("exception_wb after reset", 32'(exception_wb), 32'd0);
		for (int k = 0; k < rows.size(); k++) begin
			run_row(rows[k]);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/pipe_ctrl_pkg.sv
source/pipe_ctrl_if.sv
source/inst_decoder.sv
source/fetch_dx_ctrl.sv
source/wb_ctrl.sv
source/hazard_unit.sv
source/pipe_ctrl_top.sv
tb/pipe_ctrl_properties.sv
tb/pipe_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module pipe_ctrl_tb \
	-Mdir obj_dir -o pipe_ctrl_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pipe_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
